//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_gba_bus
RTL_TOP   ?= gba_bus_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test OK$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
design/gba_pkg.sv
design/gba_bus_if.sv
design/bus_arbiter.sv
design/mem_io.sv
design/dma_channel.sv
design/interrupt_controller.sv
design/led_controller.sv
design/gba_bus_top.sv
sim/tb_gba_bus.sv

//--- design/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter import gba_pkg::*; #(
    parameter int ADDR_W = ADDR_W_DEFAULT
) (
    input  logic      clock,
    input  logic      rst_n,
    gba_bus_if.arbiter cpu,
    gba_bus_if.arbiter dma,
    output logic      mem_en,
    output logic      mem_write,
    output addr_t     mem_addr,
    output word_t     mem_wdata,
    input  word_t     mem_rdata
);

    logic dma_sel;
    logic owner_dma;

    // DMA has fixed priority over the CPU port
    assign dma_sel   = dma.en;
    assign dma.pause = 1'b0;
    assign cpu.pause = cpu.en && dma.en;

    assign mem_en    = dma.en || cpu.en;
    assign mem_write = dma_sel ? dma.write : cpu.write;
    assign mem_addr  = dma_sel ? addr_t'(dma.addr) : addr_t'(cpu.addr);
    assign mem_wdata = dma_sel ? dma.wdata : cpu.wdata;

    // Read data goes to both masters
    assign cpu.rdata = mem_rdata;
    assign dma.rdata = mem_rdata;

    // Owner of the access taken on the last edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            owner_dma <= 1'b0;
        end else if (mem_en) begin
            owner_dma <= dma_sel;
        end
    end

    // Only one master may be granted per cycle
    a_one_grant: assert property (@(posedge clock) disable iff (!rst_n)
        !(cpu.en && !cpu.pause && dma.en && !dma.pause));

    // DMA write data is the word from its own read
    a_dma_owner: assert property (@(posedge clock) disable iff (!rst_n)
        (dma.en && dma.write) |-> owner_dma);

endmodule

//--- design/dma_channel.sv
`timescale 1ns/1ns

module dma_channel import gba_pkg::*; #(
    parameter int ADDR_W = ADDR_W_DEFAULT
) (
    input  logic       clock,
    input  logic       rst_n,
    input  addr_t      src,
    input  addr_t      dst,
    input  dma_count_t count,
    input  logic       enable,
    gba_bus_if.master  bus,
    output logic       done,
    output logic       clear
);

    dma_state_t        state;
    dma_count_t        remaining;
    logic [ADDR_W-1:0] src_ptr;
    logic [ADDR_W-1:0] dst_ptr;
    logic              start;

    // Enable is still set during the done cycle
    assign start = (state == IDLE) && enable && !done;
    assign clear = done;

    // Memory holds the word read in READ on rdata through WRITE
    assign bus.wdata = bus.rdata;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            remaining <= '0;
            done      <= 1'b0;
            bus.en    <= 1'b0;
            bus.write <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (start && count == '0) begin
                        done <= 1'b1;
                    end else if (start) begin
                        state     <= READ;
                        remaining <= count;
                        bus.en    <= 1'b1;
                        bus.write <= 1'b0;
                    end
                end
                READ: begin
                    if (!bus.pause) begin
                        state     <= WRITE;
                        bus.write <= 1'b1;
                    end
                end
                WRITE: begin
                    if (!bus.pause) begin
                        remaining <= remaining - 1'b1;
                        bus.write <= 1'b0;
                        if (remaining == dma_count_t'(1)) begin
                            state  <= IDLE;
                            bus.en <= 1'b0;
                            done   <= 1'b1;
                        end else begin
                            state <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address path
    always_ff @(posedge clock) begin
        if (start) begin
            src_ptr  <= ADDR_W'(src);
            dst_ptr  <= ADDR_W'(dst);
            bus.addr <= ADDR_W'(src);
        end else if (state == READ && !bus.pause) begin
            bus.addr <= dst_ptr;
        end else if (state == WRITE && !bus.pause) begin
            src_ptr  <= src_ptr + 1'b1;
            dst_ptr  <= dst_ptr + 1'b1;
            bus.addr <= src_ptr + 1'b1;
        end
    end

    a_en_state: assert property (@(posedge clock) disable iff (!rst_n)
        bus.en == (state != IDLE));

endmodule

//--- design/gba_bus_if.sv
`timescale 1ns/1ns

interface gba_bus_if import gba_pkg::*; #(
    parameter int ADDR_W = ADDR_W_DEFAULT
) ();

    logic [ADDR_W-1:0] addr;
    word_t             wdata;
    word_t             rdata;
    logic              write;
    logic              en;
    logic              pause;

    // Master holds en, addr, write and wdata while pause is high
    modport master (output addr, wdata, write, en, input rdata, pause);

    modport arbiter (input addr, wdata, write, en, output rdata, pause);

endinterface

//--- design/gba_bus_top.sv
`timescale 1ns/1ns

module gba_bus_top import gba_pkg::*; #(
    parameter int ADDR_W = ADDR_W_DEFAULT
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              cpu_en,
    input  logic              cpu_write,
    input  logic [ADDR_W-1:0] cpu_addr,
    input  word_t             cpu_wdata,
    output word_t             cpu_rdata,
    output logic              cpu_pause,
    input  logic [15:0]       buttons,
    input  logic [7:0]        sw,
    output logic [7:0]        ld,
    output logic              n_irq
);

    logic       mem_en;
    logic       mem_write;
    addr_t      mem_addr;
    word_t      mem_wdata;
    word_t      mem_rdata;
    addr_t      dma_src;
    addr_t      dma_dst;
    dma_count_t dma_count;
    logic       dma_enable;
    logic       dma_clear;
    logic       dma_done;
    logic       ie;
    logic       ime;
    logic       if_ack;
    logic       irq_flag;
    word_t      led_reg0;
    word_t      led_reg1;
    word_t      led_reg2;
    word_t      led_reg3;

    gba_bus_if #(.ADDR_W(ADDR_W)) cpu_bus ();
    gba_bus_if #(.ADDR_W(ADDR_W)) dma_bus ();

    // External CPU port
    assign cpu_bus.en    = cpu_en;
    assign cpu_bus.write = cpu_write;
    assign cpu_bus.addr  = cpu_addr;
    assign cpu_bus.wdata = cpu_wdata;
    assign cpu_rdata     = cpu_bus.rdata;
    assign cpu_pause     = cpu_bus.pause;

    bus_arbiter #(.ADDR_W(ADDR_W)) arb0 (
        .clock, .rst_n, .cpu(cpu_bus.arbiter), .dma(dma_bus.arbiter),
        .mem_en, .mem_write, .mem_addr, .mem_wdata, .mem_rdata
    );

    mem_io #(.ADDR_W(ADDR_W)) mem0 (
        .clock, .rst_n, .mem_en, .mem_write, .mem_addr, .mem_wdata, .mem_rdata,
        .dma_src, .dma_dst, .dma_count, .dma_enable, .dma_clear,
        .ie, .ime, .if_ack, .irq_flag,
        .led_reg0, .led_reg1, .led_reg2, .led_reg3
    );

    dma_channel #(.ADDR_W(ADDR_W)) dma0 (
        .clock, .rst_n, .src(dma_src), .dst(dma_dst), .count(dma_count),
        .enable(dma_enable), .bus(dma_bus.master), .done(dma_done), .clear(dma_clear)
    );

    interrupt_controller intc0 (
        .clock, .rst_n, .done(dma_done), .ie, .ime, .if_ack, .irq_flag, .n_irq
    );

    led_controller led0 (
        .sw, .led_reg0, .led_reg1, .led_reg2, .led_reg3, .buttons, .ld
    );

endmodule

//--- design/gba_pkg.sv
package gba_pkg;

    // Bus data word
    typedef logic [31:0] word_t;

    // Word address, top bit selects IO space
    localparam int ADDR_W_DEFAULT = 10;
    typedef logic [ADDR_W_DEFAULT-1:0] addr_t;

    // IO register index from the low address bits
    typedef logic [3:0] io_idx_t;

    // DMA transfer length in words
    typedef logic [15:0] dma_count_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE
    } dma_state_t;

    // IO register map
    localparam io_idx_t IO_DMA_SRC = 4'd0;
    localparam io_idx_t IO_DMA_DST = 4'd1;
    // Bit 31 enable, bits 15:0 word count
    localparam io_idx_t IO_DMA_CNT = 4'd2;
    localparam io_idx_t IO_IE      = 4'd3;
    // Reads the flag, write 1 to acknowledge
    localparam io_idx_t IO_IF      = 4'd4;
    localparam io_idx_t IO_IME     = 4'd5;
    localparam io_idx_t IO_LED0    = 4'd6;
    localparam io_idx_t IO_LED1    = 4'd7;
    localparam io_idx_t IO_LED2    = 4'd8;
    localparam io_idx_t IO_LED3    = 4'd9;

    localparam int NUM_IO_REGS = 10;

endpackage

//--- design/interrupt_controller.sv
`timescale 1ns/1ns

module interrupt_controller (
    input  logic clock,
    input  logic rst_n,
    input  logic done,
    input  logic ie,
    input  logic ime,
    input  logic if_ack,
    output logic irq_flag,
    output logic n_irq
);

    logic flag_next;

    // Set wins over acknowledge
    assign flag_next = done || (irq_flag && !if_ack);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            irq_flag <= 1'b0;
            n_irq    <= 1'b1;
        end else begin
            irq_flag <= flag_next;
            // Line follows the flag on the same edge
            n_irq    <= !(ime && ie && flag_next);
        end
    end

endmodule

//--- design/led_controller.sv
`timescale 1ns/1ns

module led_controller (
    input  logic [7:0]  sw,
    input  logic [31:0] led_reg0,
    input  logic [31:0] led_reg1,
    input  logic [31:0] led_reg2,
    input  logic [31:0] led_reg3,
    input  logic [15:0] buttons,
    output logic [7:0]  ld
);

    logic [31:0] regs [4];

    assign regs[0] = led_reg0;
    assign regs[1] = led_reg1;
    assign regs[2] = led_reg2;
    assign regs[3] = led_reg3;

    always_comb begin
        if (sw[7:4] == 4'h0) begin
            // Register sw/4, byte sw mod 4
            ld = regs[sw[3:2]][8*sw[1:0] +: 8];
        end else begin
            ld = sw[7] ? ~buttons[15:8] : ~buttons[7:0];
        end
    end

endmodule

//--- design/mem_io.sv
`timescale 1ns/1ns

module mem_io import gba_pkg::*; #(
    parameter int ADDR_W = ADDR_W_DEFAULT
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       mem_en,
    input  logic       mem_write,
    input  addr_t      mem_addr,
    input  word_t      mem_wdata,
    output word_t      mem_rdata,
    output addr_t      dma_src,
    output addr_t      dma_dst,
    output dma_count_t dma_count,
    output logic       dma_enable,
    input  logic       dma_clear,
    output logic       ie,
    output logic       ime,
    output logic       if_ack,
    input  logic       irq_flag,
    output word_t      led_reg0,
    output word_t      led_reg1,
    output word_t      led_reg2,
    output word_t      led_reg3
);

    localparam int RAM_WORDS = 2 ** (ADDR_W - 1);

    word_t             ram [RAM_WORDS];
    word_t             io_regs [NUM_IO_REGS];
    logic              is_io;
    logic [ADDR_W-2:0] ram_idx;
    io_idx_t           io_idx;
    logic              io_wr;
    logic              cnt_en_wr;
    word_t             io_rd;

    assign is_io     = mem_addr[ADDR_W-1];
    assign ram_idx   = mem_addr[ADDR_W-2:0];
    assign io_idx    = io_idx_t'(mem_addr);
    assign io_wr     = mem_en && mem_write && is_io;
    assign cnt_en_wr = io_wr && (io_idx == IO_DMA_CNT) && mem_wdata[31];

    // IF is not stored here, a write acknowledges the flag
    assign if_ack = io_wr && (io_idx == IO_IF) && mem_wdata[0];

    always_comb begin
        if (io_idx == IO_IF) begin
            io_rd = {31'b0, irq_flag};
        end else if (int'(io_idx) < NUM_IO_REGS) begin
            io_rd = io_regs[io_idx];
        end else begin
            io_rd = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (mem_en && mem_write && !is_io) begin
            ram[ram_idx] <= mem_wdata;
        end
    end

    // Read data stays until the next read
    always_ff @(posedge clock) begin
        if (mem_en && !mem_write) begin
            mem_rdata <= is_io ? io_rd : ram[ram_idx];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_IO_REGS; i++) begin
                io_regs[i] <= '0;
            end
        end else begin
            if (dma_clear) begin
                io_regs[IO_DMA_CNT][31] <= 1'b0;
            end
            if (io_wr && io_idx != IO_IF && int'(io_idx) < NUM_IO_REGS) begin
                io_regs[io_idx] <= mem_wdata;
            end
        end
    end

    assign dma_src    = addr_t'(io_regs[IO_DMA_SRC]);
    assign dma_dst    = addr_t'(io_regs[IO_DMA_DST]);
    assign dma_count  = io_regs[IO_DMA_CNT][15:0];
    assign dma_enable = io_regs[IO_DMA_CNT][31];
    assign ie         = io_regs[IO_IE][0];
    assign ime        = io_regs[IO_IME][0];
    assign led_reg0   = io_regs[IO_LED0];
    assign led_reg1   = io_regs[IO_LED1];
    assign led_reg2   = io_regs[IO_LED2];
    assign led_reg3   = io_regs[IO_LED3];

    // Completion clear never races a new enable write
    a_clear_vs_enable: assert property (@(posedge clock) disable iff (!rst_n)
        !(dma_clear && cnt_en_wr));

endmodule

//--- sim/tb_gba_bus.sv
`timescale 1ns/1ns

module tb_gba_bus import gba_pkg::*; ();

    localparam int ADDR_W       = ADDR_W_DEFAULT;
    localparam int RAM_WORDS    = 2 ** (ADDR_W - 1);
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_RAM      = 16;
    // Up to three cycles per CPU access plus two per DMA word
    localparam int MAX_ACCESSES = 100;
    localparam int DMA_WORDS    = 22;
    localparam int BUDGET       = RESET_CYCLES + 3 * MAX_ACCESSES + 2 * DMA_WORDS + 40;

    logic        clock;
    logic        rst_n;
    logic        cpu_en;
    logic        cpu_write;
    addr_t       cpu_addr;
    word_t       cpu_wdata;
    word_t       cpu_rdata;
    logic        cpu_pause;
    logic [15:0] buttons;
    logic [7:0]  sw;
    logic [7:0]  ld;
    logic        n_irq;

    // Reference model state
    word_t      shadow [RAM_WORDS];
    word_t      io_m [NUM_IO_REGS];
    logic       flag_m;
    logic       flag_nx;
    logic       nirq_m;
    logic       take_m;
    logic       kick;
    logic       kick_d;
    logic       ack_m;
    dma_count_t cnt_d;
    int         busy_left;
    logic       done_m;
    logic       chk_rd;
    word_t      exp_rd;
    word_t      led_word;
    logic [7:0] exp_ld;

    int errors;
    int tests;
    int failed;
    int err_mark;

    gba_bus_top #(.ADDR_W(ADDR_W)) dut0 (
        .clock, .rst_n, .cpu_en, .cpu_write, .cpu_addr, .cpu_wdata,
        .cpu_rdata, .cpu_pause, .buttons, .sw, .ld, .n_irq
    );

    function automatic addr_t io_addr(io_idx_t idx);
        return addr_t'(idx) | (addr_t'(1) << (ADDR_W - 1));
    endfunction

    function automatic int ram_slot(word_t base, int offset);
        return (int'(base[ADDR_W-2:0]) + offset) % RAM_WORDS;
    endfunction

    function automatic word_t model_read(addr_t a);
        io_idx_t idx;
        idx = io_idx_t'(a);
        if (!a[ADDR_W-1]) begin
            return shadow[a[ADDR_W-2:0]];
        end
        if (idx == IO_IF) begin
            return {31'b0, flag_m};
        end
        return (int'(idx) < NUM_IO_REGS) ? io_m[idx] : '0;
    endfunction

    // An access is taken when requested and no DMA word is in flight
    assign take_m  = cpu_en && busy_left == 0;
    assign kick    = take_m && cpu_write && cpu_addr == io_addr(IO_DMA_CNT) && cpu_wdata[31];
    assign ack_m   = take_m && cpu_write && cpu_addr == io_addr(IO_IF) && cpu_wdata[0];
    assign flag_nx = done_m ? 1'b1 : (ack_m ? 1'b0 : flag_m);

    always_comb begin
        led_word = io_m[IO_LED0 + int'(sw) / 4];
        if (sw < 8'd16) begin
            exp_ld = led_word[8 * (int'(sw) % 4) +: 8];
        end else if (sw[7]) begin
            exp_ld = ~buttons[15:8];
        end else begin
            exp_ld = ~buttons[7:0];
        end
    end

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_IO_REGS; i++) begin
                io_m[i] <= '0;
            end
            flag_m    <= 1'b0;
            nirq_m    <= 1'b1;
            kick_d    <= 1'b0;
            cnt_d     <= '0;
            busy_left <= 0;
            done_m    <= 1'b0;
            chk_rd    <= 1'b0;
            exp_rd    <= '0;
        end else begin
            flag_m <= flag_nx;
            nirq_m <= !(io_m[IO_IME][0] && io_m[IO_IE][0] && flag_nx);
            kick_d <= kick;
            cnt_d  <= cpu_wdata[15:0];
            done_m <= (kick_d && cnt_d == '0) || busy_left == 1;
            // Copy lands at once, the CPU cannot see RAM until the DMA ends
            if (kick_d) begin
                busy_left <= 2 * int'(cnt_d);
                for (int i = 0; i < int'(cnt_d); i++) begin
                    shadow[ram_slot(io_m[IO_DMA_DST], i)] <= shadow[ram_slot(io_m[IO_DMA_SRC], i)];
                end
            end else if (busy_left > 0) begin
                busy_left <= busy_left - 1;
            end
            if (done_m) begin
                io_m[IO_DMA_CNT][31] <= 1'b0;
            end
            chk_rd <= take_m && !cpu_write;
            if (take_m && !cpu_write) begin
                exp_rd <= model_read(cpu_addr);
            end
            if (take_m && cpu_write && !cpu_addr[ADDR_W-1]) begin
                shadow[cpu_addr[ADDR_W-2:0]] <= cpu_wdata;
            end else if (take_m && cpu_write && io_idx_t'(cpu_addr) != IO_IF) begin
                io_m[io_idx_t'(cpu_addr)] <= cpu_wdata;
            end
        end
    end

    a_rdata: assert property (@(posedge clock) disable iff (!rst_n)
        chk_rd |-> cpu_rdata == exp_rd)
    else begin
        errors++;
        $display("MISMATCH t=%0t cpu_rdata expected %h got %h",
                 $time, $sampled(exp_rd), $sampled(cpu_rdata));
    end

    // Paused exactly while requesting during a DMA transfer
    a_pause: assert property (@(posedge clock) disable iff (!rst_n)
        cpu_pause == (cpu_en && busy_left != 0))
    else begin
        errors++;
        $display("MISMATCH t=%0t cpu_pause expected %b got %b", $time,
                 $sampled(cpu_en) && $sampled(busy_left) != 0, $sampled(cpu_pause));
    end

    a_irq: assert property (@(posedge clock) disable iff (!rst_n) n_irq == nirq_m)
    else begin
        errors++;
        $display("MISMATCH t=%0t n_irq expected %b got %b", $time, $sampled(nirq_m),
                 $sampled(n_irq));
    end

    a_led: assert property (@(posedge clock) disable iff (!rst_n) ld == exp_ld)
    else begin
        errors++;
        $display("MISMATCH t=%0t ld expected %h got %h", $time, $sampled(exp_ld), $sampled(ld));
    end

    task automatic cpu_access(input logic wr, input addr_t a, input word_t d);
        @(posedge clock);
        cpu_en    <= 1'b1;
        cpu_write <= wr;
        cpu_addr  <= a;
        cpu_wdata <= d;
        @(negedge clock);
        while (cpu_pause) begin
            @(negedge clock);
        end
        @(posedge clock);
        cpu_en <= 1'b0;
    endtask

    task automatic fill_block(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            cpu_access(1'b1, addr_t'(base + i), $urandom);
        end
    endtask

    task automatic start_dma(input int src, input int dst, input int n);
        cpu_access(1'b1, io_addr(IO_DMA_SRC), word_t'(src));
        cpu_access(1'b1, io_addr(IO_DMA_DST), word_t'(dst));
        cpu_access(1'b1, io_addr(IO_DMA_CNT), 32'h8000_0000 | word_t'(n));
    endtask

    task automatic finish_test(input string name);
        repeat (2) @(negedge clock);
        tests++;
        if (errors > err_mark) begin
            failed++;
        end
        $display("%-14s %s (%0d errors)", name, (errors > err_mark) ? "failed" : "passed",
                 errors - err_mark);
        err_mark = errors;
    endtask

    task automatic test_ram();
        addr_t addrs [NUM_RAM];
        for (int i = 0; i < NUM_RAM; i++) begin
            addrs[i] = addr_t'($urandom_range(255));
            cpu_access(1'b1, addrs[i], $urandom);
        end
        for (int i = 0; i < NUM_RAM; i++) begin
            cpu_access(1'b0, addrs[i], '0);
        end
        finish_test("ram access");
    endtask

    task automatic test_led();
        for (int i = 0; i < 4; i++) begin
            cpu_access(1'b1, io_addr(io_idx_t'(IO_LED0 + i)), $urandom);
        end
        for (int s = 0; s < 16; s++) begin
            @(posedge clock);
            sw <= 8'(s);
        end
        @(posedge clock);
        sw      <= 8'h80;
        buttons <= 16'($urandom);
        @(posedge clock);
        sw      <= 8'h10;
        buttons <= 16'($urandom);
        @(posedge clock);
        sw <= 8'h00;
        finish_test("led mux");
    endtask

    task automatic test_dma();
        fill_block(256, 8);
        start_dma(256, 384, 8);
        // Held off until the copy is over
        cpu_access(1'b0, addr_t'(256), '0);
        for (int i = 0; i < 8; i++) begin
            cpu_access(1'b0, addr_t'(384 + i), '0);
        end
        cpu_access(1'b0, io_addr(IO_DMA_CNT), '0);
        finish_test("dma copy");
    endtask

    task automatic test_arb();
        addr_t target;
        word_t data;
        target = addr_t'($urandom_range(255));
        data   = $urandom;
        fill_block(300, 6);
        start_dma(300, 420, 6);
        cpu_access(1'b1, target, data);
        cpu_access(1'b0, target, '0);
        // Zero count finishes without a bus cycle
        cpu_access(1'b1, io_addr(IO_DMA_CNT), 32'h8000_0000);
        cpu_access(1'b1, target, ~data);
        cpu_access(1'b0, target, '0);
        finish_test("arbitration");
    endtask

    task automatic test_irq();
        cpu_access(1'b1, io_addr(IO_IF), 32'd1);
        cpu_access(1'b1, io_addr(IO_IME), 32'd1);
        cpu_access(1'b1, io_addr(IO_IE), 32'd1);
        fill_block(256, 4);
        start_dma(256, 448, 4);
        cpu_access(1'b0, addr_t'(256), '0);
        cpu_access(1'b0, io_addr(IO_IF), '0);
        cpu_access(1'b1, io_addr(IO_IF), 32'd1);
        cpu_access(1'b1, io_addr(IO_IE), 32'd0);
        start_dma(256, 448, 4);
        cpu_access(1'b0, addr_t'(256), '0);
        cpu_access(1'b0, io_addr(IO_IF), '0);
        finish_test("interrupts");
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(2 * BUDGET * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a bus access never completed", 2 * BUDGET);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(81189));
        errors    = 0;
        tests     = 0;
        failed    = 0;
        err_mark  = 0;
        rst_n     = 1'b0;
        cpu_en    = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        buttons   = '1;
        sw        = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        rst_n <= 1'b1;
        test_ram();
        test_led();
        test_dma();
        test_arb();
        test_irq();
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
